//--- hdl/rdma_pkg.sv
/* RDMA receive metadata
   shared definitions */

package rdma_pkg;

  // Region layout.
  localparam int N_REGIONS      = 3;  // User regions served behind the arbiter.
  localparam int N_REGIONS_BITS = 2;  // Width of a region index.
  localparam int PID_BITS       = 6;  // Process-ID bits at the bottom of the QPN.

  // Descriptor field widths.
  localparam int QPN_BITS    = 24;  // Queue-pair number.
  localparam int OPCODE_BITS = 5;   // RDMA opcode.
  localparam int VADDR_BITS  = 48;  // Virtual address.
  localparam int LEN_BITS    = 32;  // Transfer length in bytes.

  // One packed descriptor as it is stored in a region queue.
  localparam int REQ_BITS = OPCODE_BITS + QPN_BITS + VADDR_BITS + LEN_BITS;

  // Per-region queue sizing.
  localparam int QUEUE_DEPTH    = 4;                      // Entries in each queue.
  localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);    // Read and write pointer width.
  localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);  // Occupancy, 0 up to full.

  localparam int DROP_CNT_BITS = 16;  // Saturating counter of rejected descriptors.

  // Field types.
  typedef logic [OPCODE_BITS-1:0]    opcode_t;    // RDMA opcode.
  typedef logic [QPN_BITS-1:0]       qpn_t;       // Queue-pair number.
  typedef logic [VADDR_BITS-1:0]     vaddr_t;     // Virtual address.
  typedef logic [LEN_BITS-1:0]       len_t;       // Length in bytes.
  typedef logic [N_REGIONS_BITS-1:0] region_t;    // Region index taken from the QPN.

  // Packed order is opcode, qpn, vaddr, len from the top bit down.
  typedef logic [REQ_BITS-1:0] req_word_t;

  typedef logic [DROP_CNT_BITS-1:0] drop_cnt_t;  // Drop counter value.

endpackage

//--- hdl/rdma_meta_rx_slicer.sv
/* RDMA RX metadata input slice */

`timescale 1ns/1ps

module rdma_meta_rx_slicer (
  input  logic                aclk,
  input  logic                arst_n,

  // Descriptors from the network stack.
  input  logic                s_valid,
  output logic                s_ready,
  input  rdma_pkg::opcode_t   s_opcode,
  input  rdma_pkg::qpn_t      s_qpn,
  input  rdma_pkg::vaddr_t    s_vaddr,
  input  rdma_pkg::len_t      s_len,

  // Registered descriptors towards the arbiter.
  output logic                m_valid,
  input  logic                m_ready,
  output rdma_pkg::opcode_t   m_opcode,
  output rdma_pkg::qpn_t      m_qpn,
  output rdma_pkg::vaddr_t    m_vaddr,
  output rdma_pkg::len_t      m_len,

  output rdma_pkg::drop_cnt_t drop_cnt  // Descriptors rejected by the region check.
);

  import rdma_pkg::*;

  region_t s_region;  // Region index of the arriving descriptor.
  logic    s_keep;    // High when that region exists.
  logic    s_fire;    // Input transfer this cycle.

  // Free when empty, or when the held entry leaves in this same cycle.
  assign s_ready = !m_valid || m_ready;
  assign s_fire  = s_valid && s_ready;

  // Region bits sit right above the process ID.
  assign s_region = s_qpn[PID_BITS +: N_REGIONS_BITS];
  assign s_keep   = 32'(s_region) < N_REGIONS;

  // Valid flag of the one-entry register.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (s_fire) begin
      m_valid <= s_keep;  // A dropped descriptor leaves the slot empty.
    end else if (m_ready) begin
      m_valid <= 1'b0;  // Held entry was taken and nothing replaced it.
    end
  end

  // Payload is only loaded for descriptors that go on.
  always_ff @(posedge aclk) begin
    if (s_fire && s_keep) begin
      m_opcode <= s_opcode;
      m_qpn    <= s_qpn;
      m_vaddr  <= s_vaddr;
      m_len    <= s_len;
    end
  end

  // Saturating drop counter.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      drop_cnt <= '0;
    end else if (s_fire && !s_keep && (drop_cnt != '1)) begin
      drop_cnt <= drop_cnt + drop_cnt_t'(1);  // Stays at all ones once reached.
    end
  end

endmodule

//--- hdl/rdma_meta_queue.sv
/* Per-region descriptor FIFO */

`timescale 1ns/1ps

module rdma_meta_queue (
  input  logic                aclk,
  input  logic                arst_n,

  // Write side, fed by the arbiter demux.
  input  logic                wr_valid,
  output logic                wr_ready,
  input  rdma_pkg::req_word_t wr_data,

  // Read side, towards the user region.
  output logic                rd_valid,
  input  logic                rd_ready,
  output rdma_pkg::req_word_t rd_data
);

  import rdma_pkg::*;

  req_word_t                 mem [QUEUE_DEPTH];  // Descriptor storage.
  logic [QUEUE_PTR_BITS-1:0] wr_ptr;             // Next slot to write.
  logic [QUEUE_PTR_BITS-1:0] rd_ptr;             // Oldest stored entry.
  logic [QUEUE_CNT_BITS-1:0] count;              // Entries currently held.
  logic                      wr_fire;
  logic                      rd_fire;

  // Ready drops only when every slot is taken.
  assign wr_ready = count != QUEUE_CNT_BITS'(QUEUE_DEPTH);
  assign rd_valid = count != '0;  // Registered, so a write shows up one edge later.
  assign rd_data  = mem[rd_ptr];

  assign wr_fire = wr_valid && wr_ready;
  assign rd_fire = rd_valid && rd_ready;

  // Storage write.
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        // Wrap explicitly so any depth works.
        wr_ptr <= (wr_ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + QUEUE_PTR_BITS'(1);
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + QUEUE_PTR_BITS'(1);
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + QUEUE_CNT_BITS'(1);  // Write only.
        2'b01:   count <= count - QUEUE_CNT_BITS'(1);  // Read only.
        default: count <= count;         // Both or neither leaves occupancy as is.
      endcase
    end
  end

endmodule

//--- hdl/rdma_meta_rx_arbiter.sv
/* RDMA RX metadata region arbiter */

`timescale 1ns/1ps

module rdma_meta_rx_arbiter (
  input  logic                          aclk,
  input  logic                          arst_n,

  // Shared descriptor input from the slicer.
  input  logic                          s_valid,
  output logic                          s_ready,
  input  rdma_pkg::opcode_t             s_opcode,
  input  rdma_pkg::qpn_t                s_qpn,
  input  rdma_pkg::vaddr_t              s_vaddr,
  input  rdma_pkg::len_t                s_len,

  // One descriptor stream per user region.
  output logic [rdma_pkg::N_REGIONS-1:0] m_valid,
  input  logic [rdma_pkg::N_REGIONS-1:0] m_ready,
  output rdma_pkg::opcode_t             m_opcode [rdma_pkg::N_REGIONS],
  output rdma_pkg::qpn_t                m_qpn    [rdma_pkg::N_REGIONS],
  output rdma_pkg::vaddr_t              m_vaddr  [rdma_pkg::N_REGIONS],
  output rdma_pkg::len_t                m_len    [rdma_pkg::N_REGIONS],

  output rdma_pkg::region_t             vfid  // Region addressed by the current input.
);

  import rdma_pkg::*;

  req_word_t              s_word;             // Packed input descriptor.
  logic [N_REGIONS-1:0]   q_wr_valid;         // Demuxed valid, one hot at most.
  logic [N_REGIONS-1:0]   q_wr_ready;         // Free space flags of the queues.
  req_word_t              q_rd_word [N_REGIONS];  // Queue outputs, still packed.

  // Region index comes straight from the current QPN.
  assign vfid   = s_qpn[PID_BITS +: N_REGIONS_BITS];
  assign s_word = {s_opcode, s_qpn, s_vaddr, s_len};

  // Demux valid and return the addressed queue's ready.
  always_comb begin
    s_ready = 1'b0;  // Nonexistent region never accepts.
    for (int i = 0; i < N_REGIONS; i++) begin
      q_wr_valid[i] = s_valid && (vfid == region_t'(i));
      if (vfid == region_t'(i)) begin
        s_ready = q_wr_ready[i];
      end
    end
  end

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
    rdma_meta_queue u_queue (
      .aclk     (aclk),
      .arst_n   (arst_n),
      .wr_valid (q_wr_valid[i]),
      .wr_ready (q_wr_ready[i]),
      .wr_data  (s_word),          // Every queue sees the word, only one sees valid.
      .rd_valid (m_valid[i]),
      .rd_ready (m_ready[i]),
      .rd_data  (q_rd_word[i])
    );

    // Split the stored word back into fields.
    assign {m_opcode[i], m_qpn[i], m_vaddr[i], m_len[i]} = q_rd_word[i];
  end

endmodule

//--- hdl/rdma_meta_rx_top.sv
/* RDMA RX metadata path top level */

`timescale 1ns/1ps

module rdma_meta_rx_top (
  input  logic                          aclk,
  input  logic                          arst_n,

  // Request descriptors from the network stack.
  input  logic                          s_valid,
  output logic                          s_ready,
  input  rdma_pkg::opcode_t             s_opcode,
  input  rdma_pkg::qpn_t                s_qpn,
  input  rdma_pkg::vaddr_t              s_vaddr,
  input  rdma_pkg::len_t                s_len,

  // Per-region descriptor outputs to the user regions.
  output logic [rdma_pkg::N_REGIONS-1:0] m_valid,
  input  logic [rdma_pkg::N_REGIONS-1:0] m_ready,
  output rdma_pkg::opcode_t             m_opcode [rdma_pkg::N_REGIONS],
  output rdma_pkg::qpn_t                m_qpn    [rdma_pkg::N_REGIONS],
  output rdma_pkg::vaddr_t              m_vaddr  [rdma_pkg::N_REGIONS],
  output rdma_pkg::len_t                m_len    [rdma_pkg::N_REGIONS],

  // Status.
  output rdma_pkg::region_t             vfid,      // Region of the descriptor at the arbiter.
  output rdma_pkg::drop_cnt_t           drop_cnt   // Descriptors for missing regions.
);

  import rdma_pkg::*;

  // Slicer to arbiter link.
  logic    slc_valid;
  logic    slc_ready;
  opcode_t slc_opcode;
  qpn_t    slc_qpn;
  vaddr_t  slc_vaddr;
  len_t    slc_len;

  // Registers the input and filters out bad regions.
  rdma_meta_rx_slicer u_slicer (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_opcode (s_opcode),
    .s_qpn    (s_qpn),
    .s_vaddr  (s_vaddr),
    .s_len    (s_len),
    .m_valid  (slc_valid),
    .m_ready  (slc_ready),
    .m_opcode (slc_opcode),
    .m_qpn    (slc_qpn),
    .m_vaddr  (slc_vaddr),
    .m_len    (slc_len),
    .drop_cnt (drop_cnt)
  );

  // Steers each descriptor into its region queue.
  rdma_meta_rx_arbiter u_arbiter (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .s_valid  (slc_valid),
    .s_ready  (slc_ready),  // Low while the addressed queue is full.
    .s_opcode (slc_opcode),
    .s_qpn    (slc_qpn),
    .s_vaddr  (slc_vaddr),
    .s_len    (slc_len),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_opcode (m_opcode),
    .m_qpn    (m_qpn),
    .m_vaddr  (m_vaddr),
    .m_len    (m_len),
    .vfid     (vfid)
  );

endmodule

//--- dv/rdma_meta_rx_tb.sv
/* RDMA RX metadata testbench */

`timescale 1ns/1ps

module rdma_meta_rx_tb;

  import rdma_pkg::*;

  localparam int TBL_LEN      = 24;                           // Rows in the stimulus table.
  localparam int BURST_FIRST  = TBL_LEN - (QUEUE_DEPTH + 2);  // First row of the burst phase.
  localparam int BURST_REGION = 1;                            // Region stalled during the burst.
  localparam int CYCLE_LIMIT  = TBL_LEN * 20 + 100;           // Run length bound in cycles.
  localparam int QPN_HI_BITS  = QPN_BITS - N_REGIONS_BITS - PID_BITS;

  logic                 aclk = 1'b0;
  logic                 arst_n;
  logic                 s_valid;
  logic                 s_ready;
  opcode_t              s_opcode;
  qpn_t                 s_qpn;
  vaddr_t               s_vaddr;
  len_t                 s_len;
  logic [N_REGIONS-1:0] m_valid;
  logic [N_REGIONS-1:0] m_ready = '0;
  opcode_t              m_opcode [N_REGIONS];
  qpn_t                 m_qpn    [N_REGIONS];
  vaddr_t               m_vaddr  [N_REGIONS];
  len_t                 m_len    [N_REGIONS];
  region_t              vfid;
  drop_cnt_t            drop_cnt;

  // Stimulus table, with the expected region of every row.
  opcode_t tbl_opcode [TBL_LEN];
  qpn_t    tbl_qpn    [TBL_LEN];
  vaddr_t  tbl_vaddr  [TBL_LEN];
  len_t    tbl_len    [TBL_LEN];
  region_t tbl_region [TBL_LEN];

  int                   exp_q [N_REGIONS][$];  // Row numbers still owed by each region.
  int                   cur_row;               // Row currently on the s_ ports.
  int                   mon_row;
  int                   cycles = 0;
  logic                 checking = 1'b0;       // Monitor runs once reset is over.
  logic                 vfid_known = 1'b0;     // Slice register has held a kept row.
  region_t              vfid_exp;
  logic [N_REGIONS-1:0] hold_low = '0;         // Sinks forced to stall.
  logic                 stall_seen;
  integer               seed = 32'he68e814c;
  logic [31:0]          rnd;

  rdma_meta_rx_top UUT (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_opcode (s_opcode),
    .s_qpn    (s_qpn),
    .s_vaddr  (s_vaddr),
    .s_len    (s_len),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_opcode (m_opcode),
    .m_qpn    (m_qpn),
    .m_vaddr  (m_vaddr),
    .m_len    (m_len),
    .vfid     (vfid),
    .drop_cnt (drop_cnt)
  );

  always #5 aclk = ~aclk;  // 10 ns period.

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s = %b, expected %b",
                               $time, name, act, exp));
    end
  endtask

  task automatic compare_region(input string name, input region_t act, input region_t exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error at time %0t: %s = %0d, expected %0d",
                               $time, name, act, exp));
    end
  endtask

  task automatic compare_drop_cnt(input drop_cnt_t act, input drop_cnt_t exp);
    if (act !== exp) begin
      report_failure($sformatf("** Error at time %0t: drop_cnt = %0d, expected %0d",
                               $time, act, exp));
    end
  endtask

  // All four fields of one delivered descriptor against its table row.
  task automatic compare_req(input int region, input opcode_t act_opcode, input qpn_t act_qpn,
                             input vaddr_t act_vaddr, input len_t act_len, input int row);
    if (act_opcode !== tbl_opcode[row]) begin
      report_failure($sformatf("** Error at time %0t: m_opcode[%0d] = 0x%0h, expected 0x%0h",
                               $time, region, act_opcode, tbl_opcode[row]));
    end
    if (act_qpn !== tbl_qpn[row]) begin
      report_failure($sformatf("** Error at time %0t: m_qpn[%0d] = 0x%0h, expected 0x%0h",
                               $time, region, act_qpn, tbl_qpn[row]));
    end
    if (act_vaddr !== tbl_vaddr[row]) begin
      report_failure($sformatf("** Error at time %0t: m_vaddr[%0d] = 0x%0h, expected 0x%0h",
                               $time, region, act_vaddr, tbl_vaddr[row]));
    end
    if (act_len !== tbl_len[row]) begin
      report_failure($sformatf("** Error at time %0t: m_len[%0d] = 0x%0h, expected 0x%0h",
                               $time, region, act_len, tbl_len[row]));
    end
  endtask

  // The region index is placed just above the process-ID bits of the QPN.
  task automatic set_row(input int idx, input opcode_t opcode, input logic [QPN_HI_BITS-1:0] hi,
                         input region_t region, input logic [PID_BITS-1:0] pid,
                         input vaddr_t vaddr, input len_t len);
    tbl_opcode[idx] = opcode;
    tbl_qpn[idx]    = {hi, region, pid};
    tbl_vaddr[idx]  = vaddr;
    tbl_len[idx]    = len;
    tbl_region[idx] = region;
  endtask

  function automatic drop_cnt_t count_drops(input int first, input int last);
    drop_cnt_t n;
    n = '0;
    for (int r = first; r <= last; r++) begin
      if (int'(tbl_region[r]) >= N_REGIONS) n = n + drop_cnt_t'(1);  // No such region.
    end
    return n;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < N_REGIONS; i++) n += exp_q[i].size();
    return n;
  endfunction

  // Present one row and return once its transfer edge is due.
  task automatic drive_row(input int idx);
    @(posedge aclk);
    cur_row = idx;
    s_valid  <= 1'b1;
    s_opcode <= tbl_opcode[idx];
    s_qpn    <= tbl_qpn[idx];
    s_vaddr  <= tbl_vaddr[idx];
    s_len    <= tbl_len[idx];
    @(negedge aclk);
    while (!s_ready) @(negedge aclk);  // Held until accepted.
  endtask

  task automatic end_drive();
    @(posedge aclk);
    s_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    while (pending_count() != 0) @(negedge aclk);
    repeat (8) @(negedge aclk);  // Give any stray output time to show.
  endtask

  // Random sinks, unless forced low.
  always @(posedge aclk) begin
    for (int i = 0; i < N_REGIONS; i++) begin
      rnd = $random(seed);
      m_ready[i] <= hold_low[i] ? 1'b0 : rnd[0];
    end
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      report_failure($sformatf("Timeout after %0d cycles with %0d descriptors undelivered",
                               cycles, pending_count()));
    end
  end

  // Scoreboard monitor; values here are the ones the next rising edge sees.
  always @(negedge aclk) begin
    if (checking) begin
      for (int i = 0; i < N_REGIONS; i++) begin
        if (m_valid[i] && m_ready[i]) begin
          if (exp_q[i].size() == 0) begin
            report_failure($sformatf("Region %0d delivered a descriptor it was never sent", i));
          end else begin
            mon_row = exp_q[i].pop_front();  // Oldest outstanding row of this region.
            compare_req(i, m_opcode[i], m_qpn[i], m_vaddr[i], m_len[i], mon_row);
          end
        end
      end
      if (vfid_known) compare_region("vfid", vfid, vfid_exp);
      if (s_valid && s_ready && (int'(tbl_region[cur_row]) < N_REGIONS)) begin
        exp_q[tbl_region[cur_row]].push_back(cur_row);
        vfid_exp   = tbl_region[cur_row];  // Arbiter sees it after the accept edge.
        vfid_known = 1'b1;
      end
    end
  end

  initial begin
    arst_n   = 1'b0;
    s_valid  = 1'b0;
    s_opcode = '0;
    s_qpn    = '0;
    s_vaddr  = '0;
    s_len    = '0;
    cur_row  = 0;

    //      row  opcode  qpn high  reg   pid    vaddr              len
    set_row(0,  5'h0a, 16'h0001, 2'd0, 6'h01, 48'h0000_1000_0000, 32'h0000_0040);
    set_row(1,  5'h0c, 16'h0002, 2'd1, 6'h02, 48'h0000_2000_0040, 32'h0000_1000);
    set_row(2,  5'h10, 16'h0003, 2'd2, 6'h03, 48'h0000_3000_0080, 32'h0000_0200);
    set_row(3,  5'h06, 16'h0004, 2'd3, 6'h04, 48'h0000_4000_00c0, 32'h0000_0010);
    set_row(4,  5'h0a, 16'h0005, 2'd0, 6'h3f, 48'h7fff_ffff_f000, 32'hffff_ffff);
    set_row(5,  5'h11, 16'hffff, 2'd1, 6'h00, 48'hffff_ffff_ffff, 32'h0000_0001);
    set_row(6,  5'h0c, 16'h1234, 2'd1, 6'h15, 48'h1234_5678_9abc, 32'h0000_0800);
    set_row(7,  5'h1f, 16'h0abc, 2'd2, 6'h2a, 48'h0000_0000_0000, 32'h0000_0000);
    set_row(8,  5'h0a, 16'h8000, 2'd3, 6'h3f, 48'hdead_beef_0000, 32'h0001_0000);
    set_row(9,  5'h06, 16'h0042, 2'd0, 6'h05, 48'h0001_0000_0100, 32'h0000_0100);
    set_row(10, 5'h10, 16'h0043, 2'd0, 6'h06, 48'h0001_0000_0200, 32'h0000_0100);
    set_row(11, 5'h0c, 16'h0044, 2'd2, 6'h07, 48'h0002_0000_0300, 32'h0000_0400);
    set_row(12, 5'h11, 16'h0045, 2'd3, 6'h08, 48'h0002_0000_0400, 32'h0000_0400);
    set_row(13, 5'h0a, 16'h0046, 2'd1, 6'h09, 48'h0003_0000_0500, 32'h0000_2000);
    set_row(14, 5'h00, 16'h0047, 2'd2, 6'h0a, 48'h0003_0000_0600, 32'h0000_0080);
    set_row(15, 5'h04, 16'h0048, 2'd0, 6'h0b, 48'h0004_0000_0700, 32'h0000_0020);
    set_row(16, 5'h06, 16'h0049, 2'd3, 6'h0c, 48'h0004_0000_0800, 32'h0000_0004);
    set_row(17, 5'h0a, 16'h004a, 2'd1, 6'h0d, 48'h0005_0000_0900, 32'h0000_0008);
    // Burst, all to one region.
    set_row(18, 5'h0a, 16'h0100, 2'd1, 6'h20, 48'h00aa_0000_0000, 32'h0000_0100);
    set_row(19, 5'h0c, 16'h0101, 2'd1, 6'h21, 48'h00aa_0000_1000, 32'h0000_0200);
    set_row(20, 5'h10, 16'h0102, 2'd1, 6'h22, 48'h00aa_0000_2000, 32'h0000_0300);
    set_row(21, 5'h11, 16'h0103, 2'd1, 6'h23, 48'h00aa_0000_3000, 32'h0000_0400);
    set_row(22, 5'h06, 16'h0104, 2'd1, 6'h24, 48'h00aa_0000_4000, 32'h0000_0500);
    set_row(23, 5'h04, 16'h0105, 2'd1, 6'h25, 48'h00aa_0000_5000, 32'h0000_0600);

    repeat (4) @(posedge aclk);
    arst_n <= 1'b1;
    @(negedge aclk);
    compare_flag("s_ready", s_ready, 1'b1);
    for (int i = 0; i < N_REGIONS; i++) begin
      compare_flag($sformatf("m_valid[%0d]", i), m_valid[i], 1'b0);
    end
    compare_drop_cnt(drop_cnt, '0);
    checking = 1'b1;

    // Mixed regions against randomly stalling sinks.
    for (int r = 0; r < BURST_FIRST; r++) drive_row(r);
    end_drive();
    wait_drained();
    compare_drop_cnt(drop_cnt, count_drops(0, BURST_FIRST - 1));

    // Queue fills up, so the shared input must stall until the sink wakes.
    @(negedge aclk);
    hold_low[BURST_REGION] = 1'b1;
    stall_seen = 1'b0;
    fork
      begin
        for (int r = BURST_FIRST; r < TBL_LEN; r++) drive_row(r);
        end_drive();
      end
      begin
        while (!stall_seen) begin
          @(negedge aclk);
          if (s_valid && !s_ready) stall_seen = 1'b1;
        end
        repeat (3) @(negedge aclk);
        hold_low[BURST_REGION] = 1'b0;
      end
    join
    wait_drained();

    compare_drop_cnt(drop_cnt, count_drops(0, TBL_LEN - 1));
    compare_flag("s_ready", s_ready, 1'b1);
    for (int i = 0; i < N_REGIONS; i++) begin
      compare_flag($sformatf("m_valid[%0d]", i), m_valid[i], 1'b0);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- list.f
hdl/rdma_pkg.sv
hdl/rdma_meta_rx_slicer.sv
hdl/rdma_meta_queue.sv
hdl/rdma_meta_rx_arbiter.sv
hdl/rdma_meta_rx_top.sv
dv/rdma_meta_rx_tb.sv

//--- Makefile
# Verilator flow for the RDMA RX metadata path.

LOG := sim.log

.PHONY: all lint sim clean

all: sim

# Lint the design alone, with every warning on.
lint:
	verilator --lint-only -Wall --timing -f list.f --top-module rdma_meta_rx_top

# Build and run the testbench, then decide from the log.
sim:
	verilator --binary --timing -f list.f --top-module rdma_meta_rx_tb \
		-o rdma_meta_rx_sim
	./obj_dir/rdma_meta_rx_sim | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
